//--- hdl/hci_pkg.sv
// **********************************************************************
// Shared widths, CSR addresses and field layout of the PIO queue block
// **********************************************************************
`default_nettype none

package hci_pkg;

  localparam int unsigned CsrAddrWidth = 12;
  localparam int unsigned CsrDataWidth = 32;
  localparam int unsigned CmdWidth     = 64;  // Two COMMAND_PORT dwords
  localparam int unsigned ThldWidth    = 8;

  // Register map
  localparam logic [CsrAddrWidth-1:0] AddrResetControl  = 12'h010;
  localparam logic [CsrAddrWidth-1:0] AddrCommandPort   = 12'h080;
  localparam logic [CsrAddrWidth-1:0] AddrResponsePort  = 12'h084;
  localparam logic [CsrAddrWidth-1:0] AddrQueueThldCtrl = 12'h090;

  // RESET_CONTROL flush bits
  localparam int unsigned CmdRstBit  = 1;
  localparam int unsigned RespRstBit = 2;

  // QUEUE_THLD_CTRL fields
  localparam int unsigned CmdThldLsb  = 0;  // Command empty space
  localparam int unsigned RespThldLsb = 8;  // Response fill level

  localparam logic [ThldWidth-1:0] CmdThldReset  = 8'd1;
  localparam logic [ThldWidth-1:0] RespThldReset = 8'd1;

endpackage : hci_pkg

`default_nettype wire

//--- hdl/queue_ctrl_if.sv
// **********************************************************************
// Flush strobes and thresholds from the register block to the queues
// **********************************************************************
`default_nettype none

interface queue_ctrl_if;
  import hci_pkg::*;

  logic                 cmd_flush;   // One-cycle flush pulses
  logic                 resp_flush;
  logic [ThldWidth-1:0] cmd_thld;
  logic [ThldWidth-1:0] resp_thld;

  modport regs (output cmd_flush, output resp_flush, output cmd_thld, output resp_thld);

  modport queue (input cmd_flush, input resp_flush, input cmd_thld, input resp_thld);

endinterface : queue_ctrl_if

`default_nettype wire

//--- hdl/hci_csr.sv
// **********************************************************************
// CSR decoder with RESET_CONTROL, QUEUE_THLD_CTRL and the PIO ports
// Requests are single-cycle strobes, acknowledged one cycle later
// **********************************************************************
`default_nettype none

module hci_csr (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             req_i,
  input  logic                             req_is_wr_i,
  input  logic [hci_pkg::CsrAddrWidth-1:0] addr_i,
  input  logic [hci_pkg::CsrDataWidth-1:0] wr_data_i,
  input  logic                             drop_i,
  input  logic                             resp_valid_i,
  input  logic [hci_pkg::CsrDataWidth-1:0] resp_data_i,
  output logic                             rd_ack_o,
  output logic                             rd_err_o,
  output logic [hci_pkg::CsrDataWidth-1:0] rd_data_o,
  output logic                             wr_ack_o,
  output logic                             wr_err_o,
  output logic                             cmd_dword_wr_o,
  output logic [hci_pkg::CsrDataWidth-1:0] cmd_dword_o,
  output logic                             resp_pop_o,
  queue_ctrl_if.regs                       ctrl
);
  import hci_pkg::*;

  logic                    is_rd;
  logic                    is_wr;
  logic                    rst_ctrl_wr;
  logic                    thld_wr;
  logic                    cmd_rst_q;
  logic                    resp_rst_q;
  logic [ThldWidth-1:0]    cmd_thld_q;
  logic [ThldWidth-1:0]    resp_thld_q;
  logic [CsrDataWidth-1:0] thld_word;
  logic                    rd_err_d;
  logic                    wr_err_d;
  logic [CsrDataWidth-1:0] rd_data_d;
  logic                    rd_ack_q;
  logic                    rd_err_q;
  logic [CsrDataWidth-1:0] rd_data_q;
  logic                    wr_ack_q;
  logic                    wr_err_q;

  assign is_rd = req_i && !req_is_wr_i;
  assign is_wr = req_i && req_is_wr_i;

  assign rst_ctrl_wr = is_wr && (addr_i == AddrResetControl);
  assign thld_wr     = is_wr && (addr_i == AddrQueueThldCtrl);

  // Port strobes go out in the request cycle
  assign cmd_dword_wr_o = is_wr && (addr_i == AddrCommandPort);
  assign cmd_dword_o    = wr_data_i;
  assign resp_pop_o     = is_rd && (addr_i == AddrResponsePort);

  always_comb begin
    thld_word = '0;
    thld_word[CmdThldLsb +: ThldWidth]  = cmd_thld_q;
    thld_word[RespThldLsb +: ThldWidth] = resp_thld_q;
  end

  always_comb begin
    rd_err_d  = 1'b0;
    rd_data_d = '0;
    wr_err_d  = 1'b0;
    if (is_rd) begin
      case (addr_i)
        AddrResetControl:  rd_data_d = '0;  // Flush bits self-clear
        AddrQueueThldCtrl: rd_data_d = thld_word;
        AddrResponsePort: begin
          if (resp_valid_i) begin
            rd_data_d = resp_data_i;
          end else begin
            rd_err_d = 1'b1;  // Empty response queue
          end
        end
        default:           rd_err_d = 1'b1;  // COMMAND_PORT or unmapped
      endcase
    end
    if (is_wr) begin
      case (addr_i)
        AddrResetControl,
        AddrQueueThldCtrl: wr_err_d = 1'b0;
        AddrCommandPort:   wr_err_d = drop_i;  // Pair lost on a full queue
        default:           wr_err_d = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_rst_q   <= 1'b0;
      resp_rst_q  <= 1'b0;
      cmd_thld_q  <= CmdThldReset;
      resp_thld_q <= RespThldReset;
      rd_ack_q    <= 1'b0;
      rd_err_q    <= 1'b0;
      wr_ack_q    <= 1'b0;
      wr_err_q    <= 1'b0;
    end else begin
      cmd_rst_q  <= rst_ctrl_wr && wr_data_i[CmdRstBit];
      resp_rst_q <= rst_ctrl_wr && wr_data_i[RespRstBit];
      if (thld_wr) begin
        cmd_thld_q  <= wr_data_i[CmdThldLsb +: ThldWidth];
        resp_thld_q <= wr_data_i[RespThldLsb +: ThldWidth];
      end
      rd_ack_q <= is_rd;
      rd_err_q <= rd_err_d;
      wr_ack_q <= is_wr;
      wr_err_q <= wr_err_d;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_data_q <= rd_data_d;
  end

  assign rd_ack_o  = rd_ack_q;
  assign rd_err_o  = rd_err_q;
  assign rd_data_o = rd_data_q;
  assign wr_ack_o  = wr_ack_q;
  assign wr_err_o  = wr_err_q;

  assign ctrl.cmd_flush  = cmd_rst_q;
  assign ctrl.resp_flush = resp_rst_q;
  assign ctrl.cmd_thld   = cmd_thld_q;
  assign ctrl.resp_thld  = resp_thld_q;

endmodule : hci_csr

`default_nettype wire

//--- hdl/cmd_dword_packer.sv
// **********************************************************************
// Packs two COMMAND_PORT dwords into one command for the command queue
// **********************************************************************
`default_nettype none

module cmd_dword_packer (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             dword_wr_i,
  input  logic [hci_pkg::CsrDataWidth-1:0] dword_i,
  input  logic                             wready_i,
  output logic                             drop_o,
  output logic                             wvalid_o,
  output logic [hci_pkg::CmdWidth-1:0]     wdata_o,
  queue_ctrl_if.queue                      ctrl
);
  import hci_pkg::*;

  logic                    phase_q;  // Low dword held
  logic [CsrDataWidth-1:0] low_q;
  logic                    second;

  assign second = dword_wr_i && phase_q;

  assign wvalid_o = second;
  assign wdata_o  = {dword_i, low_q};
  assign drop_o   = second && !wready_i;  // Pair lost without room

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= 1'b0;
    end else if (ctrl.cmd_flush) begin
      phase_q <= 1'b0;  // Discard a half-filled pair
    end else if (dword_wr_i) begin
      phase_q <= !phase_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dword_wr_i && !phase_q) begin
      low_q <= dword_i;
    end
  end

endmodule : cmd_dword_packer

`default_nettype wire

//--- hdl/pio_queue.sv
// **********************************************************************
// Circular FIFO with flush and a free or used entry threshold trigger
// **********************************************************************
`default_nettype none

module pio_queue #(
  parameter int unsigned Depth     = 4,
  parameter int unsigned Width     = 32,
  parameter bit          CountFree = 1'b0  // Trigger on free entries
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  logic [hci_pkg::ThldWidth-1:0] thld_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,
  input  logic [Width-1:0]              wdata_i,
  output logic                          rvalid_o,
  input  logic                          rready_i,
  output logic [Width-1:0]              rdata_o,
  output logic                          full_o,
  output logic                          empty_o,
  output logic                          thld_trig_o
);
  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);
  localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(Depth - 1);

  logic [Width-1:0]    mem_q [Depth];
  logic [PtrWidth-1:0] wptr_q;
  logic [PtrWidth-1:0] rptr_q;
  logic [CntWidth-1:0] count_q;
  logic [CntWidth-1:0] level;
  logic                push;
  logic                pop;

  assign full_o   = (count_q == CntWidth'(Depth));
  assign empty_o  = (count_q == '0);
  assign wready_o = !full_o;
  assign rvalid_o = !empty_o;
  assign rdata_o  = mem_q[rptr_q];

  assign push = wvalid_i && wready_o;
  assign pop  = rvalid_o && rready_i;

  // Free space or fill level
  assign level = CountFree ? CntWidth'(Depth) - count_q : count_q;
  assign thld_trig_o = (32'(level) >= 32'(thld_i)) && (CountFree || !empty_o);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == LastPtr) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == LastPtr) ? '0 : rptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

endmodule : pio_queue

`default_nettype wire

//--- hdl/hci_top.sv
// **********************************************************************
// PIO queue block top with CSR decoder, command packer and both FIFOs
// **********************************************************************
`default_nettype none

module hci_top #(
  parameter int unsigned CmdDepth  = 4,
  parameter int unsigned RespDepth = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // CSR request port
  input  logic                             req_i,
  input  logic                             req_is_wr_i,
  input  logic [hci_pkg::CsrAddrWidth-1:0] addr_i,
  input  logic [hci_pkg::CsrDataWidth-1:0] wr_data_i,
  output logic                             rd_ack_o,
  output logic                             rd_err_o,
  output logic [hci_pkg::CsrDataWidth-1:0] rd_data_o,
  output logic                             wr_ack_o,
  output logic                             wr_err_o,
  // Command stream to the controller
  output logic                             cmd_rvalid_o,
  input  logic                             cmd_rready_i,
  output logic [hci_pkg::CmdWidth-1:0]     cmd_rdata_o,
  // Response stream from the controller
  input  logic                             resp_wvalid_i,
  output logic                             resp_wready_o,
  input  logic [hci_pkg::CsrDataWidth-1:0] resp_wdata_i,
  // Queue status
  output logic                             cmd_full_o,
  output logic                             cmd_empty_o,
  output logic                             cmd_thld_trig_o,
  output logic                             resp_full_o,
  output logic                             resp_empty_o,
  output logic                             resp_thld_trig_o
);
  import hci_pkg::*;

  logic                    drop;
  logic                    cmd_dword_wr;
  logic [CsrDataWidth-1:0] cmd_dword;
  logic                    resp_pop;
  logic                    resp_rvalid;
  logic [CsrDataWidth-1:0] resp_rdata;
  logic                    cmd_wvalid;
  logic                    cmd_wready;
  logic [CmdWidth-1:0]     cmd_wdata;

  queue_ctrl_if ctrl_if ();

  hci_csr csr_i (
    .clk_i, .rst_ni,
    .req_i, .req_is_wr_i, .addr_i, .wr_data_i,
    .drop_i         (drop),
    .resp_valid_i   (resp_rvalid),
    .resp_data_i    (resp_rdata),
    .rd_ack_o, .rd_err_o, .rd_data_o, .wr_ack_o, .wr_err_o,
    .cmd_dword_wr_o (cmd_dword_wr),
    .cmd_dword_o    (cmd_dword),
    .resp_pop_o     (resp_pop),
    .ctrl           (ctrl_if.regs)
  );

  cmd_dword_packer packer_i (
    .clk_i, .rst_ni,
    .dword_wr_i (cmd_dword_wr),
    .dword_i    (cmd_dword),
    .wready_i   (cmd_wready),
    .drop_o     (drop),
    .wvalid_o   (cmd_wvalid),
    .wdata_o    (cmd_wdata),
    .ctrl       (ctrl_if.queue)
  );

  pio_queue #(.Depth(CmdDepth), .Width(CmdWidth), .CountFree(1'b1)) cmd_queue (
    .clk_i, .rst_ni,
    .flush_i     (ctrl_if.cmd_flush),
    .thld_i      (ctrl_if.cmd_thld),
    .wvalid_i    (cmd_wvalid),
    .wready_o    (cmd_wready),
    .wdata_i     (cmd_wdata),
    .rvalid_o    (cmd_rvalid_o),
    .rready_i    (cmd_rready_i),
    .rdata_o     (cmd_rdata_o),
    .full_o      (cmd_full_o),
    .empty_o     (cmd_empty_o),
    .thld_trig_o (cmd_thld_trig_o)
  );

  pio_queue #(.Depth(RespDepth), .Width(CsrDataWidth), .CountFree(1'b0)) resp_queue (
    .clk_i, .rst_ni,
    .flush_i     (ctrl_if.resp_flush),
    .thld_i      (ctrl_if.resp_thld),
    .wvalid_i    (resp_wvalid_i),
    .wready_o    (resp_wready_o),
    .wdata_i     (resp_wdata_i),
    .rvalid_o    (resp_rvalid),
    .rready_i    (resp_pop),  // Popped by RESPONSE_PORT reads
    .rdata_o     (resp_rdata),
    .full_o      (resp_full_o),
    .empty_o     (resp_empty_o),
    .thld_trig_o (resp_thld_trig_o)
  );

endmodule : hci_top

`default_nettype wire

//--- bench/hci_tb.sv
// **********************************************************************
// Vector-driven testbench for the PIO queue block
// Reads bench/hci_vectors.txt and models the controller side
// **********************************************************************
`default_nettype none

module hci_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import hci_pkg::*;

  localparam int CmdDepth     = 4;
  localparam int RespDepth    = 4;
  localparam int AckTimeout   = 8;
  localparam int DrainTimeout = 64;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        req_i;
  logic        req_is_wr_i;
  logic [11:0] addr_i;
  logic [31:0] wr_data_i;
  logic        rd_ack_o, rd_err_o, wr_ack_o, wr_err_o;
  logic [31:0] rd_data_o;
  logic        cmd_rvalid_o, cmd_rready_i;
  logic [63:0] cmd_rdata_o;
  logic        resp_wvalid_i, resp_wready_o;
  logic [31:0] resp_wdata_i;
  logic        cmd_full_o, cmd_empty_o, cmd_thld_trig_o;
  logic        resp_full_o, resp_empty_o, resp_thld_trig_o;

  int          seed = 32'he8da;
  int          checks = 0;
  int          mismatches = 0;
  int          failures = 0;
  logic [63:0] cmd_model[$];   // Commands the controller should see
  logic [31:0] resp_model[$];
  logic        phase = 1'b0;   // Half-filled command pair
  logic [31:0] low_dword;
  int          cmd_thld = 1;
  int          resp_thld = 1;

  hci_top #(.CmdDepth(CmdDepth), .RespDepth(RespDepth)) dut_i (.*);

  always #2 clk_i = ~clk_i;

  task automatic compare_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      mismatches++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flags();
    int cmd_n;
    int resp_n;
    cmd_n  = cmd_model.size();
    resp_n = resp_model.size();
    compare_value("cmd_full_o", 64'(cmd_full_o), 64'(cmd_n == CmdDepth));
    compare_value("cmd_empty_o", 64'(cmd_empty_o), 64'(cmd_n == 0));
    compare_value("cmd_rvalid_o", 64'(cmd_rvalid_o), 64'(cmd_n > 0));
    compare_value("cmd_thld_trig_o", 64'(cmd_thld_trig_o), 64'((CmdDepth - cmd_n) >= cmd_thld));
    compare_value("resp_full_o", 64'(resp_full_o), 64'(resp_n == RespDepth));
    compare_value("resp_empty_o", 64'(resp_empty_o), 64'(resp_n == 0));
    compare_value("resp_wready_o", 64'(resp_wready_o), 64'(resp_n < RespDepth));
    compare_value("resp_thld_trig_o", 64'(resp_thld_trig_o),
                  64'(resp_n >= resp_thld && resp_n > 0));
  endtask

  task automatic csr_access(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                            input logic [31:0] exp_data, input logic exp_err);
    int   cycles;
    logic acked;
    @(posedge clk_i);
    #1;
    req_i       = 1'b1;
    req_is_wr_i = wr;
    addr_i      = addr;
    wr_data_i   = data;
    @(posedge clk_i);
    #1;
    req_i  = 1'b0;
    cycles = 0;
    acked  = 1'b0;
    while (!acked && cycles < AckTimeout) begin
      @(negedge clk_i);
      acked = wr ? wr_ack_o : rd_ack_o;
      cycles++;
    end
    assert (acked) else begin
      failures++;
      $display("No acknowledge for the CSR access at 0x%h by %0t ns", addr, $time);
    end
    if (acked && wr) begin
      compare_value("wr_err_o", 64'(wr_err_o), 64'(exp_err));
    end else if (acked) begin
      compare_value("rd_err_o", 64'(rd_err_o), 64'(exp_err));
      compare_value("rd_data_o", 64'(rd_data_o), 64'(exp_data));
    end
  endtask

  // Model of what a CSR write does to the queues and thresholds
  task automatic track_write(input logic [11:0] addr, input logic [31:0] data);
    if (addr == AddrCommandPort) begin
      if (!phase) begin
        low_dword = data;
        phase     = 1'b1;
      end else begin
        phase = 1'b0;
        if (cmd_model.size() < CmdDepth) cmd_model.push_back({data, low_dword});
      end
    end else if (addr == AddrQueueThldCtrl) begin
      cmd_thld  = 32'(data[CmdThldLsb +: ThldWidth]);
      resp_thld = 32'(data[RespThldLsb +: ThldWidth]);
    end else if (addr == AddrResetControl) begin
      if (data[CmdRstBit]) begin
        cmd_model.delete();
        phase = 1'b0;
      end
      if (data[RespRstBit]) resp_model.delete();
    end
  endtask

  task automatic push_response(input logic [31:0] data);
    logic room;
    room = resp_model.size() < RespDepth;
    @(posedge clk_i);
    #1;
    resp_wvalid_i = 1'b1;
    resp_wdata_i  = data;
    @(negedge clk_i);
    compare_value("resp_wready_o", 64'(resp_wready_o), 64'(room));
    @(posedge clk_i);
    #1;
    resp_wvalid_i = 1'b0;
    if (room) resp_model.push_back(data);
  endtask

  task automatic drain_commands(input int count);
    int got;
    int cycles;
    got    = 0;
    cycles = 0;
    while (got < count && cycles < DrainTimeout) begin
      @(posedge clk_i);
      #1;
      cmd_rready_i = 1'($random(seed));
      @(negedge clk_i);
      cycles++;
      if (cmd_rvalid_o && cmd_rready_i) begin
        assert (cmd_model.size() > 0) else begin
          failures++;
          $display("A command appeared at %0t ns that was never written", $time);
        end
        if (cmd_model.size() > 0) compare_value("cmd_rdata_o", cmd_rdata_o, cmd_model.pop_front());
        got++;
      end
    end
    @(posedge clk_i);
    #1;
    cmd_rready_i = 1'b0;
    assert (got == count) else begin
      failures++;
      $display("Only %0d of %0d commands arrived by %0t ns", got, count, $time);
    end
  endtask

  initial begin : stimulus
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] addr_f, data_f, exp_f, err_f;
    req_i         = 1'b0;
    req_is_wr_i   = 1'b0;
    addr_i        = '0;
    wr_data_i     = '0;
    cmd_rready_i  = 1'b0;
    resp_wvalid_i = 1'b0;
    resp_wdata_i  = '0;
    rst_ni        = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    compare_value("acks after reset", 64'({rd_ack_o, wr_ack_o, rd_err_o, wr_err_o}), 64'(0));
    check_flags();

    fd = $fopen("bench/hci_vectors.txt", "r");
    assert (fd != 0) else begin
      failures++;
      $display("Cannot open the vector file bench/hci_vectors.txt");
    end
    while (fd != 0 && !$feof(fd)) begin
      n = 0;
      if ($fgets(line, fd) > 0) begin
        n = $sscanf(line, "%s %h %h %h %h", op, addr_f, data_f, exp_f, err_f);
      end
      if (n == 5 && op != "#") begin
        assert (op inside {"W", "R", "P", "C"}) else begin
          failures++;
          $display("Unknown operation in the vector file: %s", line);
        end
        case (op)
          "W": begin
            csr_access(1'b1, addr_f[11:0], data_f, '0, err_f[0]);
            track_write(addr_f[11:0], data_f);
          end
          "R": begin
            csr_access(1'b0, addr_f[11:0], data_f, exp_f, err_f[0]);
            if (addr_f[11:0] == AddrResponsePort && resp_model.size() > 0) resp_model.delete(0);
          end
          "P": push_response(data_f);
          "C": drain_commands(int'(addr_f));
          default: ;
        endcase
        @(negedge clk_i);  // Queue and flush effects settle
        check_flags();
      end
    end
    if (fd != 0) $fclose(fd);

    $display("Checks: %0d, mismatches: %0d, other failures: %0d", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : hci_tb

`default_nettype wire

//--- bench/hci_vectors.txt
# op addr_or_count data exp_data exp_err (hex fields)
# W csr write, R csr read, P response push, C take count commands
R 090 00000000 00000101 0
R 010 00000000 00000000 0
W 080 11110000 00000000 0
W 080 11110001 00000000 0
W 080 22220000 00000000 0
W 080 22220001 00000000 0
C 002 00000000 00000000 0
W 090 00000302 00000000 0
R 090 00000000 00000302 0
P 000 a0000001 00000000 0
P 000 a0000002 00000000 0
P 000 a0000003 00000000 0
P 000 a0000004 00000000 0
P 000 a0000005 00000000 0
R 084 00000000 a0000001 0
R 084 00000000 a0000002 0
W 080 33330000 00000000 0
W 080 33330001 00000000 0
W 080 44440000 00000000 0
W 080 44440001 00000000 0
W 080 55550000 00000000 0
W 080 55550001 00000000 0
W 080 66660000 00000000 0
W 080 66660001 00000000 0
W 080 77770000 00000000 0
W 080 77770001 00000000 1
C 004 00000000 00000000 0
W 010 00000004 00000000 0
R 010 00000000 00000000 0
R 084 00000000 00000000 1
P 000 b0000001 00000000 0
W 080 88880000 00000000 0
W 010 00000002 00000000 0
W 080 99990000 00000000 0
W 080 99990001 00000000 0
C 001 00000000 00000000 0
R 084 00000000 b0000001 0
R 200 00000000 00000000 1
W 200 00000001 00000000 1
W 084 12345678 00000000 1
R 080 00000000 00000000 1

//--- filelist.f
hdl/hci_pkg.sv
hdl/queue_ctrl_if.sv
hdl/hci_csr.sv
hdl/cmd_dword_packer.sv
hdl/pio_queue.sv
hdl/hci_top.sv
bench/hci_tb.sv

//--- Makefile
SRCS := $(shell cat filelist.f)

.PHONY: run clean

run: obj_dir/Vhci_tb
	@out="$$(./obj_dir/Vhci_tb)"; echo "$$out"; echo "$$out" | grep -q "Finished with no errors"

obj_dir/Vhci_tb: filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module hci_tb -f filelist.f

clean:
	rm -rf obj_dir
